/* cache_subsys.f */
source/cache_pkg.sv
source/cache_if.sv
source/cpu_port.sv
source/cache_array.sv
source/cache_control.sv
source/mem_port.sv
source/cache_top.sv
sim/cache_checker.sv
sim/tb_cache.sv

/* sim/cache_checker.sv */
`timescale 1ns/100ps

module cache_checker import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    input  logic [data_w-1:0] dat_r,
    input  logic              ack,
    input  logic              mem_cyc,
    input  logic              mem_stb,
    input  logic              mem_we,
    input  logic [addr_w-1:0] mem_adr,
    input  logic [data_w-1:0] mem_dat_w,
    input  logic [data_w-1:0] mem_dat_r,
    input  logic              mem_ack,
    output logic [31:0]       error_count,
    output logic [31:0]       check_count
);

    logic [data_w-1:0]     cpu_view [1 << word_w];  // last value the processor wrote
    logic [tag_w-1:0]      model_tag [line_count];
    logic [line_count-1:0] model_valid;
    logic [line_count-1:0] model_dirty;
    logic [word_w:0]       expect_ops [$];          // write flag and word address
    logic                  pending;
    logic                  in_reset;
    logic                  exp_hit;
    logic                  saw_mem;
    logic [word_w-1:0]     req_word;
    logic [word_w-1:0]     op_word;
    int                    cycle;
    int                    start_cycle;
    int                    k;

    initial begin
        error_count = 0;
        check_count = 0;
        pending     = 1'b0;
        in_reset    = 1'b0;
        cycle       = 0;
        for (k = 0; k < (1 << word_w); k++) begin
            cpu_view[k] = k ^ 32'h5a5a_0000;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic require(input logic ok, input string what);
        check_count++;
        if (!ok) begin
            $display("%s", what);
            error_count++;
        end
    endtask

    // a dirty victim goes back before the fill of the new line
    task automatic start_access();
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tag;
        req_word    = adr[addr_w-1:2];
        idx         = req_word[index_w-1:0];
        tag         = req_word[word_w-1:index_w];
        start_cycle = cycle;
        pending     = 1'b1;
        saw_mem     = 1'b0;
        exp_hit     = model_valid[idx] && (model_tag[idx] == tag);
        if (!exp_hit) begin
            if (model_valid[idx] && model_dirty[idx]) begin
                expect_ops.push_back({1'b1, model_tag[idx], idx});
            end
            expect_ops.push_back({1'b0, req_word});
        end
        model_dirty[idx] = (exp_hit && model_dirty[idx]) || we;
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
    endtask

    task automatic check_mem_transfer();
        logic [word_w:0] op;
        op_word = mem_adr[addr_w-1:2];
        saw_mem = 1'b1;
        require(expect_ops.size() != 0, "memory cycle with no miss to serve");
        if (expect_ops.size() != 0) begin
            op = expect_ops.pop_front();
            compare("mem_we", op[word_w], mem_we);
            compare("mem_adr", {op[word_w-1:0], 2'b00}, mem_adr);
            if (mem_we) begin
                compare("mem_dat_w", cpu_view[op_word], mem_dat_w);
            end else begin
                compare("mem_dat_r", cpu_view[op_word], mem_dat_r);  // memory is up to date
            end
        end
    endtask

    task automatic finish_access();
        require(cyc && stb, "ack came without cyc and stb");
        require(pending, "ack came with no request outstanding");
        require(expect_ops.size() == 0, "ack came before the expected memory cycles");
        // ack rises on the second edge after capture and shows on the next sample
        if (exp_hit) begin
            require(cycle - start_cycle == 3 && !saw_mem,
                    "hit did not ack 2 cycles after the strobe without memory traffic");
        end
        if (we) begin
            cpu_view[req_word] = dat_w;
        end else begin
            compare("dat_r", cpu_view[req_word], dat_r);
        end
        expect_ops.delete();
        pending = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst) begin
            pending     = 1'b0;
            in_reset    = 1'b1;
            model_valid = '0;
            model_dirty = '0;
            expect_ops.delete();
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                require(!ack && !mem_cyc && !mem_stb, "bus outputs not idle after reset");
                require(tb_cache.i_dut.i_control.state == st_idle,
                        "miss controller not idle after reset");
            end
            if (cyc && stb && !pending && !ack) begin
                start_access();
            end
            if (mem_cyc && mem_stb && mem_ack) begin
                check_mem_transfer();
            end
            if (ack) begin
                finish_access();
            end
        end
    end

endmodule

/* sim/tb_cache.sv */
`timescale 1ns/100ps

module tb_cache import cache_pkg::*; ();

    logic              clk, rst, cyc, stb, we, ack;
    logic              mem_cyc, mem_stb, mem_we, mem_ack;
    logic [addr_w-1:0] adr, mem_adr;
    logic [data_w-1:0] dat_w, dat_r, mem_dat_w, mem_dat_r;
    logic [data_w-1:0] backing [1 << word_w];
    logic [48:0]       entries [$];  // write flag, byte address, write data
    logic [31:0]       error_count;
    logic [31:0]       check_count;
    int                mem_wait;
    int                timeouts;
    int                n;

    cache_top i_dut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    cache_checker i_check (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory answers each bus cycle after 0 to 3 wait states
    initial begin
        void'($urandom(32'hbde1_247b));
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        mem_wait  = -1;
        forever begin
            @(negedge clk);
            if (rst || mem_ack) begin
                mem_ack  = 1'b0;
                mem_wait = -1;
            end else if (mem_cyc && mem_stb) begin
                if (mem_wait < 0) begin
                    mem_wait = $urandom_range(3, 0);
                end
                if (mem_wait == 0) begin
                    mem_ack = 1'b1;
                    if (mem_we) begin
                        backing[mem_adr[addr_w-1:2]] = mem_dat_w;
                    end else begin
                        mem_dat_r = backing[mem_adr[addr_w-1:2]];
                    end
                end
                mem_wait = mem_wait - 1;
            end
        end
    end

    task automatic add_entry(input logic wr, input logic [addr_w-1:0] a,
                             input logic [data_w-1:0] d);
        entries.push_back({wr, a, d});
    endtask

    // ack is taken on the rising edge, as a bus master samples it
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!ack && cycles < 200);
        if (!ack) begin
            $display("ack never came for address %h", adr);
            timeouts++;
        end
    endtask

    initial begin
        rst       = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        timeouts  = 0;
        for (n = 0; n < (1 << word_w); n++) begin
            backing[n] = n ^ 32'h5a5a_0000;
        end
        add_entry(1'b0, 16'h0010, 32'h0);           // cold miss with a clean fill
        add_entry(1'b0, 16'h0010, 32'h0);
        add_entry(1'b1, 16'h0010, 32'h1111_0001);
        add_entry(1'b0, 16'h0110, 32'h0);           // same index so the dirty victim goes back
        add_entry(1'b0, 16'h0110, 32'h0);
        add_entry(1'b0, 16'h0010, 32'h0);           // victim was only read
        add_entry(1'b1, 16'h0244, 32'h2222_0002);   // write miss fills first
        add_entry(1'b1, 16'h0244, 32'h2222_0003);
        add_entry(1'b0, 16'h0344, 32'h0);
        add_entry(1'b0, 16'h0244, 32'h0);
        add_entry(1'b1, 16'h1ffc, 32'h3333_0004);
        add_entry(1'b1, 16'h2ffc, 32'h3333_0005);
        add_entry(1'b1, 16'h3ffc, 32'h3333_0006);
        add_entry(1'b0, 16'h1ffc, 32'h0);
        add_entry(1'b0, 16'h2ffc, 32'h0);
        add_entry(1'b0, 16'hfffc, 32'h0);           // never written
        add_entry(1'b1, 16'h0080, 32'h4444_0007);
        add_entry(1'b0, 16'h0080, 32'h0);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (n = 0; n < entries.size() && timeouts == 0; n++) begin
            @(negedge clk);
            {we, adr, dat_w} = entries[n];
            cyc = 1'b1;
            stb = 1'b1;
            wait_ack();
            @(negedge clk);
            cyc = 1'b0;
            stb = 1'b0;
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* source/cache_array.sv */
`timescale 1ns/100ps

module cache_array import cache_pkg::*; (
    input  logic clk,
    input  logic rst,
    lookup_if.array lk,
    mem_req_if.snoop mr
);

    logic [data_w-1:0]     data_mem [line_count];
    logic [tag_w-1:0]      tag_mem  [line_count];
    logic [line_count-1:0] valid_bits;
    logic [line_count-1:0] dirty_bits;

    logic [data_w-1:0]  rd_data;
    logic [tag_w-1:0]   rd_tag;
    logic               rd_valid;
    logic               rd_dirty;
    logic               fresh;        // read registers hold the current line
    logic [index_w-1:0] idx;
    logic               fill;
    logic               wr_hit;

    assign idx    = lk.addr.line.index;
    assign fill   = mr.done && !mr.we;   // refill data arriving
    assign wr_hit = lk.hit && !lk.stall && lk.we;

    // control state of the lines
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            fresh      <= 1'b0;
        end else begin
            fresh <= lk.valid && !fill && !wr_hit;  // a line change makes the read stale
            if (fill) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= 1'b0;
            end else if (wr_hit) begin
                dirty_bits[idx] <= 1'b1;
            end
        end
    end

    // storage and registered read of the addressed line
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[idx]  <= lk.addr.line.tag;
            data_mem[idx] <= mr.rdata;
        end else if (wr_hit) begin
            data_mem[idx] <= lk.wdata;
        end
        rd_data  <= data_mem[idx];
        rd_tag   <= tag_mem[idx];
        rd_valid <= valid_bits[idx];
        rd_dirty <= dirty_bits[idx];
    end

    assign lk.ready      = fresh && lk.valid;
    assign lk.hit        = lk.ready && rd_valid && (rd_tag == lk.addr.line.tag);
    assign lk.dirty      = rd_dirty;
    assign lk.victim_tag = rd_tag;
    assign lk.rdata      = rd_data;

endmodule

/* source/cache_control.sv */
`timescale 1ns/100ps

module cache_control import cache_pkg::*; (
    input  logic clk,
    input  logic rst,
    lookup_if.control lk,
    mem_req_if.control mr
);

    miss_state_t state;
    miss_state_t next_state;
    word_addr_t  victim_addr;
    logic        miss;

    assign miss = lk.ready && !lk.hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // the victim shares the index of the request, only the tag differs
    always_comb begin
        victim_addr.line.tag   = lk.victim_tag;
        victim_addr.line.index = lk.addr.line.index;
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (miss) begin
                    if (lk.dirty) begin
                        next_state = st_back;
                    end else begin
                        next_state = st_fill;
                    end
                end
            end
            st_back: begin
                next_state = st_back_wait;
            end
            st_back_wait: begin
                if (mr.done) begin
                    next_state = st_fill;
                end
            end
            st_fill: begin
                next_state = st_fill_wait;
            end
            st_fill_wait: begin
                if (mr.done) begin
                    next_state = st_idle;  // lookup retries and now hits
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // request fields stay put through the wait states
    always_comb begin
        mr.req   = (state == st_back) || (state == st_fill);
        mr.we    = (state == st_back) || (state == st_back_wait);
        mr.wdata = lk.rdata;  // victim word from the read registers
        if (mr.we) begin
            mr.addr = victim_addr;
        end else begin
            mr.addr = lk.addr;
        end
    end

    assign lk.stall = (state != st_idle);

endmodule

/* source/cache_if.sv */
`timescale 1ns/100ps

// processor request and lookup result shared by port, array and controller
interface lookup_if import cache_pkg::*; ();
    logic              valid;       // request held until acked
    logic              we;
    word_addr_t        addr;
    logic [data_w-1:0] wdata;
    logic              ready;       // read registers match the held request
    logic              hit;
    logic              dirty;
    logic [tag_w-1:0]  victim_tag;
    logic [data_w-1:0] rdata;
    logic              stall;

    modport port (output valid, we, addr, wdata, input hit, stall, rdata);
    modport array (
        input  valid, we, addr, wdata, stall,
        output ready, hit, dirty, victim_tag, rdata
    );
    modport control (
        input  valid, addr, ready, hit, dirty, victim_tag, rdata,
        output stall
    );
endinterface

// one memory transfer from the controller to the bus master
interface mem_req_if import cache_pkg::*; ();
    logic              req;         // single cycle pulse
    logic              we;
    word_addr_t        addr;
    logic [data_w-1:0] wdata;
    logic              done;        // single cycle pulse, carries rdata on a fill
    logic [data_w-1:0] rdata;

    modport control (output req, we, addr, wdata, input done);
    modport port (input req, we, addr, wdata, output done, rdata);
    modport snoop (input done, we, rdata);
endinterface

/* source/cache_pkg.sv */
package cache_pkg;

    localparam int addr_w     = 16;
    localparam int data_w     = 32;
    localparam int tag_w      = 8;
    localparam int index_w    = 6;
    localparam int word_w     = tag_w + index_w;  // word address, byte offset dropped
    localparam int line_count = 1 << index_w;

    // one word address, seen either as a word number or split for the array
    typedef union packed {
        logic [word_w-1:0] word;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
        } line;
    } word_addr_t;

    // miss sequence, write back the victim first and then fetch the line
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_back      = 3'd1,
        st_back_wait = 3'd2,
        st_fill      = 3'd3,
        st_fill_wait = 3'd4
    } miss_state_t;

endpackage

/* source/cache_top.sv */
`timescale 1ns/100ps

module cache_top import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // processor side, Wishbone classic slave
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    output logic [data_w-1:0] dat_r,
    output logic              ack,
    // memory side, Wishbone classic master
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_adr,
    output logic [data_w-1:0] mem_dat_w,
    input  logic [data_w-1:0] mem_dat_r,
    input  logic              mem_ack
);

    lookup_if  lk ();
    mem_req_if mr ();

    cpu_port i_cpu_port (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .lk    (lk.port)
    );

    cache_array i_array (
        .clk (clk),
        .rst (rst),
        .lk  (lk.array),
        .mr  (mr.snoop)
    );

    cache_control i_control (
        .clk (clk),
        .rst (rst),
        .lk  (lk.control),
        .mr  (mr.control)
    );

    mem_port i_mem_port (
        .clk       (clk),
        .rst       (rst),
        .mr        (mr.port),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

endmodule

/* source/cpu_port.sv */
`timescale 1ns/100ps

module cpu_port import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [addr_w-1:0] adr,
    input  logic [data_w-1:0] dat_w,
    output logic [data_w-1:0] dat_r,
    output logic              ack,
    lookup_if.port            lk
);

    logic              valid_q;
    logic              we_q;
    word_addr_t        addr_q;
    logic [data_w-1:0] wdata_q;
    logic              capture;
    logic              finish;

    // a strobe still high while ack is out belongs to the transfer just ended
    assign capture = cyc && stb && !valid_q && !ack;
    assign finish  = valid_q && lk.hit && !lk.stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            ack     <= 1'b0;
        end else begin
            ack <= finish;
            if (capture) begin
                valid_q <= 1'b1;
            end else if (finish) begin
                valid_q <= 1'b0;
            end
        end
    end

    // request payload, held through any miss
    always_ff @(posedge clk) begin
        if (capture) begin
            we_q        <= we;
            addr_q.word <= adr[addr_w-1:2];  // byte offset is always zero
            wdata_q     <= dat_w;
        end
        if (finish) begin
            dat_r <= lk.rdata;
        end
    end

    assign lk.valid = valid_q;
    assign lk.we    = we_q;
    assign lk.addr  = addr_q;
    assign lk.wdata = wdata_q;

endmodule

/* source/mem_port.sv */
`timescale 1ns/100ps

module mem_port import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    mem_req_if.port           mr,
    output logic              mem_cyc,
    output logic              mem_stb,
    output logic              mem_we,
    output logic [addr_w-1:0] mem_adr,
    output logic [data_w-1:0] mem_dat_w,
    input  logic [data_w-1:0] mem_dat_r,
    input  logic              mem_ack
);

    logic              busy;
    logic              done_q;
    logic [data_w-1:0] rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            mem_we <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= busy && mem_ack;
            if (mr.req) begin
                busy   <= 1'b1;
                mem_we <= mr.we;
            end else if (busy && mem_ack) begin
                busy   <= 1'b0;  // end of the classic cycle
                mem_we <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mr.req) begin
            mem_adr   <= {mr.addr.word, 2'b00};
            mem_dat_w <= mr.wdata;
        end
        if (busy && mem_ack) begin
            rdata_q <= mem_dat_r;
        end
    end

    assign mem_cyc  = busy;
    assign mem_stb  = busy;
    assign mr.done  = done_q;
    assign mr.rdata = rdata_q;

endmodule
